/* sources.f */
design/cache_pkg.sv
design/tag_lookup.sv
design/plru_tree.sv
design/cache_controller.sv
design/line_store.sv
design/data_cache.sv
testbench/data_cache_props.sv
testbench/data_cache_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = data_cache_tb
FILELIST = sources.f
BUILD    = obj_dir
BINARY   = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD)

/* testbench/data_cache_tb.sv */
// testbench for the data cache
// clock and reset, burst memory model with random back-pressure,
// operation table with expected results, single compare task, watchdog

module data_cache_tb;

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [3:0]  be;
		logic [31:0] data;
		logic        refill;	// one memory read expected
	} op_t;

	localparam int op_count = 19;

	op_t ops [op_count] = '{
		'{1'b0, 32'h1000_0024, 4'hf, 32'h0000_0000, 1'b1},	// read miss in set 1
		'{1'b0, 32'h1000_0038, 4'hf, 32'h0000_0000, 1'b0},	// same line hits
		'{1'b1, 32'h1000_0028, 4'hf, 32'hcafe_f00d, 1'b0},	// word write hit
		'{1'b0, 32'h1000_0028, 4'hf, 32'h0000_0000, 1'b0},
		'{1'b1, 32'h1000_002e, 4'hc, 32'hbeef_0000, 1'b0},	// halfword, upper half of beat
		'{1'b0, 32'h1000_002c, 4'hf, 32'h0000_0000, 1'b0},
		'{1'b1, 32'h1000_0443, 4'h8, 32'h5a00_0000, 1'b0},	// byte write miss
		'{1'b0, 32'h1000_0440, 4'hf, 32'h0000_0000, 1'b1},	// not allocated by the write
		'{1'b1, 32'h1000_0101, 4'h2, 32'h0000_3c00, 1'b0},
		'{1'b0, 32'h1000_0100, 4'hf, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h2000_0064, 4'hf, 32'h0000_0000, 1'b1},	// lines a to d fill set 3
		'{1'b0, 32'h2000_0268, 4'hf, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h2000_046c, 4'hf, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h2000_0670, 4'hf, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h2000_0074, 4'hf, 32'h0000_0000, 1'b0},	// a again
		'{1'b0, 32'h2000_0878, 4'hf, 32'h0000_0000, 1'b1},	// e takes the way of b
		'{1'b0, 32'h2000_0060, 4'hf, 32'h0000_0000, 1'b0},
		'{1'b0, 32'h2000_0260, 4'hf, 32'h0000_0000, 1'b1},	// b is gone
		'{1'b0, 32'h2000_087c, 4'hf, 32'h0000_0000, 1'b0}	// e survives the refill of b
	};

	logic                clock;
	logic                reset;
	logic                core_read;
	logic                core_write;
	logic [31:0]         core_address;
	logic [3:0]          core_byteenable;
	logic [31:0]         core_writedata;
	logic                core_waitrequest;
	logic                core_readdatavalid;
	logic [31:0]         core_readdata;
	cache_pkg::mem_cmd_t mem_cmd;
	logic                mem_waitrequest;
	logic                mem_readdatavalid;
	logic [63:0]         mem_readdata;

	logic [31:0]         shadow [logic [31:0]];	// memory words written so far
	logic [31:0]         ref_words [logic [31:0]];
	logic [31:0]         pending [$];	// beat addresses still to return
	int                  mem_reads = 0;
	int                  mem_writes = 0;
	logic [31:0]         read_addr;
	cache_pkg::mem_cmd_t write_cmd;

	data_cache i_data_cache (.*);

	// untouched memory holds its own address with the top byte inverted
	function automatic logic [31:0] initial_word(input logic [31:0] addr);
		return addr ^ 32'hff00_0000;
	endfunction

	function automatic logic [31:0] memory_word(input logic [31:0] addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return initial_word(addr);
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (ref_words.exists(addr))
			return ref_words[addr];
		return initial_word(addr);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] be);
		logic [31:0] result;
		result = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				result[b*8 +: 8] = data[b*8 +: 8];
		end
		return result;
	endfunction

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic run_op(input op_t op);
		int          reads_before;
		int          writes_before;
		logic [31:0] word_addr;
		logic [31:0] lane_data;
		reads_before    = mem_reads;
		writes_before   = mem_writes;
		word_addr       = {op.addr[31:2], 2'b00};
		core_read       = !op.write;
		core_write      = op.write;
		core_address    = op.addr;
		core_byteenable = op.be;
		core_writedata  = op.data;
		@(posedge clock);
		#2;
		core_read  = 1'b0;
		core_write = 1'b0;
		if (op.write) begin
			ref_words[word_addr] = merge_bytes(expected_word(word_addr), op.data, op.be);
			while (core_waitrequest) begin
				@(posedge clock);
				#2;
			end
			check("memory writes", 64'(mem_writes - writes_before), 64'd1);
			check("mem_cmd.address", 64'(write_cmd.address), 64'({op.addr[31:3], 3'b000}));
			check("mem_cmd.burstcount", 64'(write_cmd.burstcount), 64'd1);
			check("mem_cmd.byteenable", 64'(write_cmd.byteenable),
				64'(op.addr[2] ? {op.be, 4'h0} : {4'h0, op.be}));
			lane_data = op.addr[2] ? write_cmd.writedata[63:32] : write_cmd.writedata[31:0];
			check("mem_cmd.writedata", 64'(lane_data), 64'(op.data));
		end else begin
			if (!op.refill)	// hit answers on the very next cycle
				check("core_readdatavalid", 64'(core_readdatavalid), 64'd1);
			while (!core_readdatavalid) begin
				@(posedge clock);
				#2;
			end
			check("core_waitrequest", 64'(core_waitrequest), 64'd0);
			check("core_readdata", 64'(core_readdata), 64'(expected_word(word_addr)));
			check("memory writes", 64'(mem_writes - writes_before), 64'd0);
			if (op.refill)
				check("refill address", 64'(read_addr), 64'({op.addr[31:5], 5'b00000}));
		end
		check("memory reads", 64'(mem_reads - reads_before), 64'(op.refill));
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin : memory_model
		logic [31:0] beat_addr;
		void'($urandom(70956));
		mem_waitrequest   = 1'b0;
		mem_readdatavalid = 1'b0;
		mem_readdata      = '0;
		forever begin
			@(negedge clock);	// command and waitrequest as seen by the next edge
			if (mem_cmd.write && !mem_waitrequest) begin
				write_cmd = mem_cmd;
				mem_writes++;
				beat_addr = mem_cmd.address;
				shadow[beat_addr] = merge_bytes(memory_word(beat_addr),
					mem_cmd.writedata[31:0], mem_cmd.byteenable[3:0]);
				shadow[beat_addr + 4] = merge_bytes(memory_word(beat_addr + 4),
					mem_cmd.writedata[63:32], mem_cmd.byteenable[7:4]);
			end
			if (mem_cmd.read && !mem_waitrequest) begin
				read_addr = mem_cmd.address;
				mem_reads++;
				check("mem_cmd.burstcount", 64'(mem_cmd.burstcount), 64'd4);
				for (int b = 0; b < 4; b++)
					pending.push_back(read_addr + 32'(b * 8));
			end
			@(posedge clock);
			#2;
			mem_waitrequest   = ($urandom % 3) == 0;
			mem_readdatavalid = 1'b0;
			if (pending.size() > 0 && ($urandom % 2) == 0) begin	// random beat gaps
				beat_addr         = pending.pop_front();
				mem_readdatavalid = 1'b1;
				mem_readdata      = {memory_word(beat_addr + 4), memory_word(beat_addr)};
			end
		end
	end

	initial begin : watchdog
		repeat (op_count * 200) @(posedge clock);
		$display("timeout: the cache did not finish the operation table in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		reset           = 1'b1;
		core_read       = 1'b0;
		core_write      = 1'b0;
		core_address    = '0;
		core_byteenable = '0;
		core_writedata  = '0;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		@(posedge clock);
		#2;
		check("core_readdatavalid", 64'(core_readdatavalid), 64'd0);
		check("core_waitrequest", 64'(core_waitrequest), 64'd0);
		check("mem_cmd.read", 64'(mem_cmd.read), 64'd0);
		check("mem_cmd.write", 64'(mem_cmd.write), 64'd0);
		for (int i = 0; i < op_count; i++)
			run_op(ops[i]);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* testbench/data_cache_props.sv */
// concurrent checks on the core and memory port handshakes
// bound into every data_cache instance

module data_cache_props (
	input logic                clock,
	input logic                reset,
	input logic                core_read,
	input logic                core_waitrequest,
	input logic                core_readdatavalid,
	input cache_pkg::mem_cmd_t mem_cmd,
	input logic                mem_waitrequest
);

	logic read_pending;	// accepted read not yet returned

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			read_pending <= 1'b0;
		else if (core_read && !core_waitrequest)
			read_pending <= 1'b1;
		else if (core_readdatavalid)
			read_pending <= 1'b0;
	end

	strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(mem_cmd.read && mem_cmd.write))
		else $error("memory read and write strobes high together");

	command_held: assert property (@(posedge clock) disable iff (reset)
		(mem_cmd.read || mem_cmd.write) && mem_waitrequest |=> $stable(mem_cmd))
		else $error("memory command changed while waitrequest was high");

	return_after_read: assert property (@(posedge clock) disable iff (reset)
		core_readdatavalid |-> read_pending)
		else $error("core_readdatavalid without an accepted read");

endmodule

bind data_cache data_cache_props i_data_cache_props (.*);

/* design/data_cache.sv */
// 4-way set-associative write-through data cache
// top level joining controller, tag lookup, replacement and line store
// to the 32-bit core port and the 64-bit burst memory port

module data_cache (
	input  logic                clock,
	input  logic                reset,
	input  logic                core_read,
	input  logic                core_write,
	input  logic [31:0]         core_address,
	input  logic [3:0]          core_byteenable,
	input  logic [31:0]         core_writedata,
	output logic                core_waitrequest,
	output logic                core_readdatavalid,
	output logic [31:0]         core_readdata,
	output cache_pkg::mem_cmd_t mem_cmd,
	input  logic                mem_waitrequest,
	input  logic                mem_readdatavalid,
	input  logic [63:0]         mem_readdata
);

	cache_pkg::core_req_t            req;
	logic                            hit;
	logic [cache_pkg::way_bits-1:0]  hit_way;
	logic [cache_pkg::way_bits-1:0]  victim_way;
	logic [cache_pkg::way_count-1:0] valid_set;
	logic                            touch;
	logic [cache_pkg::way_bits-1:0]  touch_way;
	logic                            install;
	logic                            refill_beat;
	logic [cache_pkg::beat_bits-1:0] beat_index;
	logic                            merge;
	logic                            read_word_en;
	logic [cache_pkg::way_bits-1:0]  way;

	cache_controller i_cache_controller (
		.clock              (clock),
		.reset              (reset),
		.core_read          (core_read),
		.core_write         (core_write),
		.core_address       (core_address),
		.core_byteenable    (core_byteenable),
		.core_writedata     (core_writedata),
		.hit                (hit),
		.hit_way            (hit_way),
		.victim_way         (victim_way),
		.mem_waitrequest    (mem_waitrequest),
		.mem_readdatavalid  (mem_readdatavalid),
		.core_waitrequest   (core_waitrequest),
		.core_readdatavalid (core_readdatavalid),
		.req                (req),
		.touch              (touch),
		.touch_way          (touch_way),
		.install            (install),
		.refill_beat        (refill_beat),
		.beat_index         (beat_index),
		.merge              (merge),
		.read_word_en       (read_word_en),
		.way                (way),
		.mem_cmd            (mem_cmd)
	);

	tag_lookup i_tag_lookup (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.install     (install),
		.install_way (victim_way),	// refills always land in the victim
		.hit         (hit),
		.hit_way     (hit_way),
		.valid_set   (valid_set)
	);

	plru_tree i_plru_tree (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.valid_set  (valid_set),
		.touch      (touch),
		.touch_way  (touch_way),
		.victim_way (victim_way)
	);

	line_store i_line_store (
		.clock        (clock),
		.req          (req),
		.way          (way),
		.refill_beat  (refill_beat),
		.beat_index   (beat_index),
		.mem_readdata (mem_readdata),
		.merge        (merge),
		.read_word_en (read_word_en),
		.readdata     (core_readdata)
	);

endmodule

/* design/line_store.sv */
// line store for the data cache
// data array of one line per way and set, refill beat writes,
// byte merge on write hits and registered read word select

module line_store (
	input  logic                            clock,
	input  cache_pkg::core_req_t            req,
	input  logic [cache_pkg::way_bits-1:0]  way,
	input  logic                            refill_beat,
	input  logic [cache_pkg::beat_bits-1:0] beat_index,
	input  logic [63:0]                     mem_readdata,
	input  logic                            merge,
	input  logic                            read_word_en,
	output logic [31:0]                     readdata
);

	logic [cache_pkg::line_bits-1:0] lines [cache_pkg::way_count][2**cache_pkg::index_bits];

	logic [cache_pkg::index_bits-1:0] set;
	logic [2:0]                       word;	// 32-bit word within the line
	logic [31:0]                      beat_word;
	logic                             bypass;

	assign set  = req.address.fields.index;
	assign word = {req.address.beats.beat, req.address.beats.half};

	// requested word arriving on this beat is taken from the bus
	assign bypass    = refill_beat && (beat_index == req.address.beats.beat);
	assign beat_word = req.address.beats.half ? mem_readdata[63:32] : mem_readdata[31:0];

	always_ff @(posedge clock) begin
		if (refill_beat)
			lines[way][set][beat_index*64 +: 64] <= mem_readdata;
		if (merge) begin
			for (int b = 0; b < 4; b++) begin
				if (req.byteenable[b])
					lines[way][set][word*32 + b*8 +: 8] <= req.writedata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (read_word_en) begin
			if (bypass)
				readdata <= beat_word;
			else
				readdata <= lines[way][set][word*32 +: 32];
		end
	end

endmodule

/* design/cache_controller.sv */
// cache controller
// request capture, hit and miss sequencing, refill burst and
// write-through beat on the memory port, strobes to the lookup and store

module cache_controller (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            core_read,
	input  logic                            core_write,
	input  logic [31:0]                     core_address,
	input  logic [3:0]                      core_byteenable,
	input  logic [31:0]                     core_writedata,
	input  logic                            hit,
	input  logic [cache_pkg::way_bits-1:0]  hit_way,
	input  logic [cache_pkg::way_bits-1:0]  victim_way,
	input  logic                            mem_waitrequest,
	input  logic                            mem_readdatavalid,
	output logic                            core_waitrequest,
	output logic                            core_readdatavalid,
	output cache_pkg::core_req_t            req,
	output logic                            touch,
	output logic [cache_pkg::way_bits-1:0]  touch_way,
	output logic                            install,
	output logic                            refill_beat,
	output logic [cache_pkg::beat_bits-1:0] beat_index,
	output logic                            merge,
	output logic                            read_word_en,
	output logic [cache_pkg::way_bits-1:0]  way,
	output cache_pkg::mem_cmd_t             mem_cmd
);

	cache_pkg::ctrl_state_t          state;
	cache_pkg::core_req_t            live_req;
	cache_pkg::core_req_t            held_req;
	logic [cache_pkg::beat_bits-1:0] beat_count;
	logic                            data_valid;
	logic                            accept;
	logic                            in_refill;
	logic                            last_beat;

	always_comb begin
		live_req.read       = core_read;
		live_req.write      = core_write;
		live_req.address    = core_address;
		live_req.byteenable = core_byteenable;
		live_req.writedata  = core_writedata;
	end

	// lookup sees the live request in idle so a hit answers next cycle
	assign req = (state == cache_pkg::st_idle) ? live_req : held_req;

	assign accept    = (state == cache_pkg::st_idle) && (core_read || core_write);
	assign in_refill = (state == cache_pkg::st_refill_data);
	assign last_beat = mem_readdatavalid &&
		(beat_count == cache_pkg::beat_bits'(cache_pkg::beats_per_line - 1));

	assign core_waitrequest   = (state != cache_pkg::st_idle);
	assign core_readdatavalid = data_valid;

	assign way          = (state == cache_pkg::st_idle) ? hit_way : victim_way;
	assign touch_way    = way;
	assign touch        = (accept && hit) || (in_refill && last_beat);
	assign install      = in_refill && last_beat;
	assign refill_beat  = in_refill && mem_readdatavalid;
	assign beat_index   = beat_count;
	assign merge        = accept && core_write && hit;
	assign read_word_en = (accept && core_read && hit) || (in_refill && last_beat);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state      <= cache_pkg::st_idle;
			beat_count <= '0;
			data_valid <= 1'b0;
		end else begin
			data_valid <= 1'b0;
			case (state)
				cache_pkg::st_idle: begin
					if (accept) begin
						if (core_write)
							state <= cache_pkg::st_write_beat;	// hit or not
						else if (hit)
							data_valid <= 1'b1;
						else
							state <= cache_pkg::st_refill_req;
					end
				end
				cache_pkg::st_refill_req: begin
					if (!mem_waitrequest) begin
						beat_count <= '0;
						state      <= cache_pkg::st_refill_data;
					end
				end
				cache_pkg::st_refill_data: begin
					if (mem_readdatavalid) begin
						beat_count <= beat_count + 1'b1;
						if (last_beat) begin
							data_valid <= 1'b1;
							state      <= cache_pkg::st_idle;
						end
					end
				end
				cache_pkg::st_write_beat: begin
					if (!mem_waitrequest)
						state <= cache_pkg::st_idle;
				end
				default: state <= cache_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			held_req <= live_req;
	end

	// command comes straight from state and the held request
	always_comb begin
		mem_cmd                        = '0;
		mem_cmd.read                   = (state == cache_pkg::st_refill_req);
		mem_cmd.write                  = (state == cache_pkg::st_write_beat);
		mem_cmd.address.beats.line     = held_req.address.beats.line;
		if (state == cache_pkg::st_write_beat) begin
			mem_cmd.address.beats.beat = held_req.address.beats.beat;
			mem_cmd.burstcount         = 4'd1;
			if (held_req.address.beats.half) begin
				mem_cmd.byteenable = {held_req.byteenable, 4'b0000};
				mem_cmd.writedata  = {held_req.writedata, 32'h0};
			end else begin
				mem_cmd.byteenable = {4'b0000, held_req.byteenable};
				mem_cmd.writedata  = {32'h0, held_req.writedata};
			end
		end else begin
			mem_cmd.burstcount = 4'(cache_pkg::beats_per_line);	// whole line
			mem_cmd.byteenable = 8'hff;
		end
	end

endmodule

/* design/plru_tree.sv */
// tree pseudo-LRU replacement for the data cache
// three bits per set, victim choice with empty-way priority,
// update toward the other half of the tree on every touch

module plru_tree (
	input  logic                            clock,
	input  logic                            reset,
	input  cache_pkg::core_req_t            req,
	input  logic [cache_pkg::way_count-1:0] valid_set,
	input  logic                            touch,
	input  logic [cache_pkg::way_bits-1:0]  touch_way,
	output logic [cache_pkg::way_bits-1:0]  victim_way
);

	// bit 0 root, 1 picks the odd pair
	// bit 1 pair of ways 0 and 2, bit 2 pair of ways 1 and 3
	logic [2:0] tree [2**cache_pkg::index_bits];

	logic [cache_pkg::index_bits-1:0] set;
	logic [2:0]                       node;
	logic                             leaf;

	assign set  = req.address.fields.index;
	assign node = tree[set];
	assign leaf = node[0] ? node[2] : node[1];

	always_comb begin
		victim_way = {leaf, node[0]};
		// lowest empty way takes priority
		for (int w = cache_pkg::way_count - 1; w >= 0; w--) begin
			if (!valid_set[w])
				victim_way = cache_pkg::way_bits'(w);
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < 2**cache_pkg::index_bits; s++) begin
				tree[s] <= '0;
			end
		end else if (touch) begin
			tree[set][0] <= ~touch_way[0];	// root away from the used pair
			if (touch_way[0])
				tree[set][2] <= ~touch_way[1];
			else
				tree[set][1] <= ~touch_way[1];
		end
	end

endmodule

/* design/tag_lookup.sv */
// tag lookup for the data cache
// tag and valid arrays per set and way, parallel tag compare,
// hit way encode and line install

module tag_lookup (
	input  logic                            clock,
	input  logic                            reset,
	input  cache_pkg::core_req_t            req,
	input  logic                            install,
	input  logic [cache_pkg::way_bits-1:0]  install_way,
	output logic                            hit,
	output logic [cache_pkg::way_bits-1:0]  hit_way,
	output logic [cache_pkg::way_count-1:0] valid_set
);

	logic [cache_pkg::tag_bits-1:0]  tag_mem [cache_pkg::way_count][2**cache_pkg::index_bits];
	logic [cache_pkg::way_count-1:0] valid_mem [2**cache_pkg::index_bits];

	logic [cache_pkg::index_bits-1:0] set;
	logic [cache_pkg::tag_bits-1:0]   tag;
	logic [cache_pkg::way_count-1:0]  match;

	assign set = req.address.fields.index;
	assign tag = req.address.fields.tag;

	assign valid_set = valid_mem[set];

	// compare all ways at once
	always_comb begin
		for (int w = 0; w < cache_pkg::way_count; w++) begin
			match[w] = valid_set[w] && (tag_mem[w][set] == tag);
		end
	end

	assign hit = |match;

	// at most one way matches, lowest wins anyway
	always_comb begin
		hit_way = '0;
		for (int w = cache_pkg::way_count - 1; w >= 0; w--) begin
			if (match[w])
				hit_way = cache_pkg::way_bits'(w);
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < 2**cache_pkg::index_bits; s++) begin
				valid_mem[s] <= '0;
			end
		end else if (install) begin
			valid_mem[set][install_way] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (install)
			tag_mem[install_way][set] <= tag;	// new line's tag
	end

endmodule

/* design/cache_pkg.sv */
// shared definitions for the 4-way data cache
// geometry constants, address decodings, request and memory command structs
// and the controller state type

package cache_pkg;

	// 32-byte lines, 16 sets, 4 ways
	localparam int offset_bits    = 5;
	localparam int index_bits     = 4;
	localparam int tag_bits       = 23;
	localparam int way_count      = 4;
	localparam int way_bits       = 2;
	localparam int beats_per_line = 4;	// 64-bit beats on the memory port
	localparam int beat_bits      = 2;
	localparam int line_bits      = 256;

	// lookup view of an address
	typedef struct packed {
		logic [tag_bits-1:0]    tag;
		logic [index_bits-1:0]  index;
		logic [offset_bits-1:0] offset;
	} addr_fields_t;

	// memory port view of the same address
	typedef struct packed {
		logic [31-offset_bits:0] line;
		logic [beat_bits-1:0]    beat;
		logic                    half;	// 32-bit word within the beat
		logic [1:0]              byte_sel;
	} addr_beats_t;

	typedef union packed {
		addr_fields_t fields;
		addr_beats_t  beats;
	} cache_addr_t;

	// core request as held by the controller
	typedef struct packed {
		logic        read;
		logic        write;
		cache_addr_t address;
		logic [3:0]  byteenable;
		logic [31:0] writedata;
	} core_req_t;

	// command side of the 64-bit burst port
	typedef struct packed {
		logic        read;
		logic        write;
		cache_addr_t address;
		logic [7:0]  byteenable;
		logic [3:0]  burstcount;
		logic [63:0] writedata;
	} mem_cmd_t;

	typedef enum logic [1:0] {
		st_idle,
		st_refill_req,	// burst read held until accepted
		st_refill_data,	// counting returned beats
		st_write_beat	// single write-through beat
	} ctrl_state_t;

endpackage
